// File: design/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN        = 32;
    localparam int REG_AW      = 5;
    localparam int IMM_I_MSB   = 11;
    localparam int IMM_B_MSB   = 12;  // branch/jal offset sign bit
    localparam int SHAMT_W     = 5;
    localparam int LINK_OFFSET = 4;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        CLS_NONE, CLS_INT, CLS_BRANCH, CLS_JAL, CLS_JALR
    } op_class_t;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [6:0]        opcode;
        logic [2:0]        funct3;
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;
    } instr_t;

    typedef struct packed {
        logic              reg_w_en;
        logic [REG_AW-1:0] reg_w_rd;
        logic [XLEN-1:0]   reg_w_data;
        logic              jmp_do;
        logic [XLEN-1:0]   jmp_pc;
    } result_t;

endpackage

`default_nettype wire

// File: design/exec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dec_exe_if;
    import exec_pkg::*;

    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rd;
    op_class_t         op_class;
    alu_op_t           alu_op;
    br_cond_t          br_cond;
    logic [XLEN-1:0]   opa;
    logic [XLEN-1:0]   opb;
    logic [XLEN-1:0]   cmp_a;     // rs1
    logic [XLEN-1:0]   cmp_b;     // rs2
    logic [XLEN-1:0]   tgt_base;
    logic [XLEN-1:0]   tgt_off;
    logic              clr_lsb;   // jalr target rule

    modport dec (output valid, pc, rd, op_class, alu_op, br_cond, opa, opb,
                 cmp_a, cmp_b, tgt_base, tgt_off, clr_lsb);
    modport exe (input valid, pc, rd, op_class, alu_op, br_cond, opa, opb,
                 cmp_a, cmp_b, tgt_base, tgt_off, clr_lsb);
endinterface

interface exe_res_if;
    import exec_pkg::*;

    logic              valid;
    logic [REG_AW-1:0] rd;
    op_class_t         op_class;
    logic [XLEN-1:0]   alu_result;
    logic              take;      // branch condition true
    logic [XLEN-1:0]   target;
    logic [XLEN-1:0]   link;

    modport exe (output valid, rd, op_class, alu_result, take, target, link);
    modport res (input valid, rd, op_class, alu_result, take, target, link);
endinterface

`default_nettype wire

// File: design/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [exec_pkg::XLEN-1:0]
) (
    input  logic     CLK,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     en,
    input  payload_t d,
    output payload_t q,
    output logic     q_valid
);

    always_ff @(posedge CLK) begin
        if (!rst_n || flush) begin
            q       <= '0;
            q_valid <= 1'b0;
        end else if (en) begin
            q       <= d;
            q_valid <= 1'b1;
        end else begin
            q_valid <= 1'b0;  // entry lives one cycle
        end
    end

endmodule

`default_nettype wire

// File: design/exec_decode.sv
`timescale 1ns/1ps
`default_nettype none

module exec_decode (
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             in_valid,
    input  exec_pkg::instr_t instr,
    dec_exe_if.dec           dx
);
    import exec_pkg::*;

    instr_t          ir;
    logic            ir_valid;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic            f7_ok;

    stage_reg #(.payload_t(instr_t)) u_cap (
        .CLK     (CLK),
        .rst_n   (rst_n),
        .flush   (flush),
        .en      (in_valid),
        .d       (instr),
        .q       (ir),
        .q_valid (ir_valid)
    );

    assign imm_i = {{(XLEN-IMM_I_MSB-1){ir.imm[IMM_I_MSB]}}, ir.imm[IMM_I_MSB:0]};
    assign imm_b = {{(XLEN-IMM_B_MSB-1){ir.imm[IMM_B_MSB]}}, ir.imm[IMM_B_MSB:1], 1'b0};
    assign imm_u = {ir.imm[XLEN-1:IMM_I_MSB+1], {(IMM_I_MSB+1){1'b0}}};

    // funct7 only selects between base and alt for add/sub and srl/sra
    always_comb begin
        if (ir.funct3 == F3_SR)
            f7_ok = (ir.funct7 == F7_BASE) || (ir.funct7 == F7_ALT);
        else if (ir.funct3 == F3_ADD && ir.opcode == OPC_OP)
            f7_ok = (ir.funct7 == F7_BASE) || (ir.funct7 == F7_ALT);
        else if (ir.funct3 == F3_SLL || ir.opcode == OPC_OP)
            f7_ok = (ir.funct7 == F7_BASE);
        else
            f7_ok = 1'b1;  // op-imm: funct7 is immediate
    end

    always_comb begin
        dx.valid    = ir_valid;
        dx.pc       = ir.pc;
        dx.rd       = ir.rd;
        dx.op_class = CLS_NONE;
        dx.alu_op   = ALU_ADD;
        dx.br_cond  = BR_EQ;
        dx.opa      = ir.rs1_data;
        dx.opb      = imm_i;
        dx.cmp_a    = ir.rs1_data;
        dx.cmp_b    = ir.rs2_data;
        dx.tgt_base = ir.pc;
        dx.tgt_off  = imm_b;
        dx.clr_lsb  = 1'b0;
        case (ir.opcode)
            OPC_OP, OPC_OP_IMM: begin
                if (ir.opcode == OPC_OP)
                    dx.opb = ir.rs2_data;
                dx.op_class = f7_ok ? CLS_INT : CLS_NONE;
                case (ir.funct3)
                    F3_ADD:  dx.alu_op = (ir.opcode == OPC_OP && ir.funct7 == F7_ALT) ?
                                         ALU_SUB : ALU_ADD;
                    F3_SLL:  dx.alu_op = ALU_SLL;
                    F3_SLT:  dx.alu_op = ALU_SLT;
                    F3_SLTU: dx.alu_op = ALU_SLTU;
                    F3_XOR:  dx.alu_op = ALU_XOR;
                    F3_SR:   dx.alu_op = (ir.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:   dx.alu_op = ALU_OR;
                    default: dx.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                dx.op_class = CLS_INT;
                dx.alu_op   = ALU_PASS_B;
                dx.opb      = imm_u;
            end
            OPC_AUIPC: begin
                dx.op_class = CLS_INT;
                dx.opa      = ir.pc;
                dx.opb      = imm_u;
            end
            OPC_BRANCH: begin
                dx.op_class = CLS_BRANCH;
                case (ir.funct3)
                    F3_BEQ:  dx.br_cond = BR_EQ;
                    F3_BNE:  dx.br_cond = BR_NE;
                    F3_BLT:  dx.br_cond = BR_LT;
                    F3_BGE:  dx.br_cond = BR_GE;
                    F3_BLTU: dx.br_cond = BR_LTU;
                    F3_BGEU: dx.br_cond = BR_GEU;
                    default: dx.op_class = CLS_NONE;  // 010, 011 undefined
                endcase
            end
            OPC_JAL: begin
                dx.op_class = CLS_JAL;
            end
            OPC_JALR: begin
                dx.op_class = (ir.funct3 == F3_JALR) ? CLS_JALR : CLS_NONE;
                dx.tgt_base = ir.rs1_data;
                dx.tgt_off  = imm_i;
                dx.clr_lsb  = 1'b1;
            end
            default: dx.op_class = CLS_NONE;
        endcase
    end

endmodule

`default_nettype wire

// File: design/exec_alu_branch.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu_branch (
    dec_exe_if.exe dx,
    exe_res_if.exe xr
);
    import exec_pkg::*;

    logic [SHAMT_W-1:0] sh;
    logic [XLEN-1:0]    tgt_sum;
    logic               lt_s;
    logic               lt_u;

    assign sh   = dx.opb[SHAMT_W-1:0];
    assign lt_s = $signed(dx.cmp_a) < $signed(dx.cmp_b);
    assign lt_u = dx.cmp_a < dx.cmp_b;

    assign xr.valid    = dx.valid;
    assign xr.rd       = dx.rd;
    assign xr.op_class = dx.op_class;

    always_comb begin
        case (dx.alu_op)
            ALU_ADD:    xr.alu_result = dx.opa + dx.opb;
            ALU_SUB:    xr.alu_result = dx.opa - dx.opb;
            ALU_AND:    xr.alu_result = dx.opa & dx.opb;
            ALU_OR:     xr.alu_result = dx.opa | dx.opb;
            ALU_XOR:    xr.alu_result = dx.opa ^ dx.opb;
            ALU_SLL:    xr.alu_result = dx.opa << sh;
            ALU_SRL:    xr.alu_result = dx.opa >> sh;
            ALU_SRA:    xr.alu_result = $signed(dx.opa) >>> sh;
            ALU_SLT:    xr.alu_result = {{(XLEN-1){1'b0}},
                                         $signed(dx.opa) < $signed(dx.opb)};
            ALU_SLTU:   xr.alu_result = {{(XLEN-1){1'b0}}, dx.opa < dx.opb};
            ALU_PASS_B: xr.alu_result = dx.opb;  // lui
            default:    xr.alu_result = '0;
        endcase
    end

    always_comb begin
        case (dx.br_cond)
            BR_EQ:   xr.take = (dx.cmp_a == dx.cmp_b);
            BR_NE:   xr.take = (dx.cmp_a != dx.cmp_b);
            BR_LT:   xr.take = lt_s;
            BR_GE:   xr.take = !lt_s;
            BR_LTU:  xr.take = lt_u;
            BR_GEU:  xr.take = !lt_u;
            default: xr.take = 1'b0;
        endcase
    end

    assign tgt_sum   = dx.tgt_base + dx.tgt_off;
    assign xr.target = {tgt_sum[XLEN-1:1], tgt_sum[0] & !dx.clr_lsb};  // jalr drops bit 0
    assign xr.link   = dx.pc + XLEN'(LINK_OFFSET);

endmodule

`default_nettype wire

// File: design/exec_result.sv
`timescale 1ns/1ps
`default_nettype none

module exec_result (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              flush,
    exe_res_if.res            xr,
    output exec_pkg::result_t res
);
    import exec_pkg::*;

    result_t nxt;
    result_t res_q;
    logic    res_vld;

    always_comb begin
        nxt = '0;
        if (xr.valid) begin
            case (xr.op_class)
                CLS_INT: begin
                    nxt.reg_w_en   = 1'b1;
                    nxt.reg_w_data = xr.alu_result;
                end
                CLS_BRANCH: nxt.jmp_do = xr.take;
                CLS_JAL, CLS_JALR: begin
                    nxt.reg_w_en   = 1'b1;
                    nxt.reg_w_data = xr.link;
                    nxt.jmp_do     = 1'b1;
                end
                default: nxt = '0;  // unsupported opcode
            endcase
            nxt.reg_w_rd = nxt.reg_w_en ? xr.rd : '0;
            nxt.jmp_pc   = nxt.jmp_do ? xr.target : '0;
        end
    end

    stage_reg #(.payload_t(result_t)) u_out (
        .CLK     (CLK),
        .rst_n   (rst_n),
        .flush   (flush),
        .en      (xr.valid),
        .d       (nxt),
        .q       (res_q),
        .q_valid (res_vld)
    );

    assign res = res_vld ? res_q : '0;  // one cycle per instruction

endmodule

`default_nettype wire

// File: design/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic                        CLK,
    input  logic                        rst_n,
    input  logic                        flush,
    input  logic                        in_valid,
    input  logic [exec_pkg::XLEN-1:0]   pc,
    input  logic [6:0]                  opcode,
    input  logic [2:0]                  funct3,
    input  logic [6:0]                  funct7,
    input  logic [exec_pkg::REG_AW-1:0] rd,
    input  logic [exec_pkg::XLEN-1:0]   rs1_data,
    input  logic [exec_pkg::XLEN-1:0]   rs2_data,
    input  logic [exec_pkg::XLEN-1:0]   imm,
    output logic                        reg_w_en,
    output logic [exec_pkg::REG_AW-1:0] reg_w_rd,
    output logic [exec_pkg::XLEN-1:0]   reg_w_data,
    output logic                        jmp_do,
    output logic [exec_pkg::XLEN-1:0]   jmp_pc
);
    import exec_pkg::*;

    instr_t  instr;
    result_t res;

    dec_exe_if dx_if ();
    exe_res_if xr_if ();

    assign instr = '{pc: pc, opcode: opcode, funct3: funct3, funct7: funct7, rd: rd,
                     rs1_data: rs1_data, rs2_data: rs2_data, imm: imm};

    exec_decode u_decode (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (flush),
        .in_valid (in_valid),
        .instr    (instr),
        .dx       (dx_if.dec)
    );

    exec_alu_branch u_alu (
        .dx (dx_if.exe),
        .xr (xr_if.exe)
    );

    exec_result u_result (
        .CLK   (CLK),
        .rst_n (rst_n),
        .flush (flush),
        .xr    (xr_if.res),
        .res   (res)
    );

    assign reg_w_en   = res.reg_w_en;
    assign reg_w_rd   = res.reg_w_rd;
    assign reg_w_data = res.reg_w_data;
    assign jmp_do     = res.jmp_do;
    assign jmp_pc     = res.jmp_pc;

endmodule

`default_nettype wire

// File: verif/exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exec_checker (
    input  logic                        CLK,
    input  logic                        rst_n,
    input  logic                        exp_stb,
    input  logic                        exp_en,
    input  logic [exec_pkg::REG_AW-1:0] exp_rd,
    input  logic [exec_pkg::XLEN-1:0]   exp_data,
    input  logic                        exp_jmp,
    input  logic [exec_pkg::XLEN-1:0]   exp_jpc,
    input  logic                        reg_w_en,
    input  logic [exec_pkg::REG_AW-1:0] reg_w_rd,
    input  logic [exec_pkg::XLEN-1:0]   reg_w_data,
    input  logic                        jmp_do,
    input  logic [exec_pkg::XLEN-1:0]   jmp_pc,
    output int                          n_tests,
    output int                          n_failed,
    output int                          n_other
);
    import exec_pkg::*;

    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
        logic              jmp;
        logic [XLEN-1:0]   jpc;
    } expect_t;

    expect_t exp_q[$];
    expect_t cur;
    logic    stb_d1;
    logic    stb_d2;
    logic    field_bad;
    int      tests_done = 0;
    int      tests_failed = 0;
    int      other_errs = 0;

    assign n_tests  = tests_done;
    assign n_failed = tests_failed;
    assign n_other  = other_errs;

    task automatic check_field(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        if (actv !== expv) begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expv, actv);
            field_bad = 1'b1;
        end
    endtask

    task automatic compare_entry();
        if (exp_q.size() == 0) begin
            other_errs++;
            $display("ERROR at time %0t: output cycle with no expected entry", $time);
        end else begin
            cur       = exp_q.pop_front();
            field_bad = 1'b0;
            check_field("reg_w_en", 32'(cur.en), 32'(reg_w_en));
            check_field("reg_w_rd", 32'(cur.rd), 32'(reg_w_rd));
            check_field("reg_w_data", cur.data, reg_w_data);
            check_field("jmp_do", 32'(cur.jmp), 32'(jmp_do));
            check_field("jmp_pc", cur.jpc, jmp_pc);
            tests_done++;
            if (field_bad) begin
                tests_failed++;
                $display("test %0d: FAIL", tests_done);
            end else begin
                $display("test %0d: pass", tests_done);
            end
        end
    endtask

    // strobe at edge N, result valid between N+1 and N+2
    always @(posedge CLK) begin
        if (!rst_n) begin
            stb_d1 <= 1'b0;
            stb_d2 <= 1'b0;
        end else begin
            stb_d1 <= exp_stb;
            stb_d2 <= stb_d1;
            if (exp_stb)
                exp_q.push_back(expect_t'{exp_en, exp_rd, exp_data, exp_jmp, exp_jpc});
        end
    end

    always @(negedge CLK) begin
        if (rst_n) begin
            if (stb_d2) begin
                compare_entry();
            end else if (reg_w_en !== 1'b0 || jmp_do !== 1'b0) begin
                other_errs++;
                $display("ERROR at time %0t: enable high in a cycle with no instruction due",
                         $time);
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/exec_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_sva (
    input logic                        CLK,
    input logic                        rst_n,
    input logic                        flush,
    input logic                        in_valid,
    input logic                        reg_w_en,
    input logic [exec_pkg::REG_AW-1:0] reg_w_rd,
    input logic [exec_pkg::XLEN-1:0]   reg_w_data,
    input logic                        jmp_do,
    input logic [exec_pkg::XLEN-1:0]   jmp_pc
);

    int fail_count = 0;  // read by the testbench at the end

    a_clear: assert property (@(posedge CLK) (!rst_n || flush) |=>
        (!reg_w_en && !jmp_do && reg_w_rd == '0 && reg_w_data == '0 && jmp_pc == '0))
    else begin
        fail_count++;
        $error("outputs not zero in the cycle after reset or flush");
    end

    a_jmp_align: assert property (@(posedge CLK) disable iff (!rst_n)
        jmp_do |-> !jmp_pc[0])
    else begin
        fail_count++;
        $error("jump target with bit 0 set");
    end

    // write enable only two edges after an accepted instruction
    a_wen_src: assert property (@(posedge CLK) disable iff (!rst_n)
        $rose(reg_w_en) |-> $past(in_valid, 2))
    else begin
        fail_count++;
        $error("reg_w_en rose without a valid instruction two edges before");
    end

endmodule

bind exec_stage exec_stage_sva sva_i (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .flush      (flush),
    .in_valid   (in_valid),
    .reg_w_en   (reg_w_en),
    .reg_w_rd   (reg_w_rd),
    .reg_w_data (reg_w_data),
    .jmp_do     (jmp_do),
    .jmp_pc     (jmp_pc)
);

`default_nettype wire

// File: verif/tb_exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage;
    import exec_pkg::*;

    typedef struct {
        logic [XLEN-1:0]   pc;
        logic [6:0]        opcode;
        logic [2:0]        funct3;
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;
        logic              gap;
        logic              flush_after;
        logic              e_en;
        logic [REG_AW-1:0] e_rd;
        logic [XLEN-1:0]   e_data;
        logic              e_jmp;
        logic [XLEN-1:0]   e_jpc;
    } row_t;

    row_t rows[$];
    bit   table_ready = 1'b0;

    logic              CLK;
    logic              rst_n;
    logic              flush;
    logic              in_valid;
    logic [XLEN-1:0]   pc;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;
    logic              reg_w_en;
    logic [REG_AW-1:0] reg_w_rd;
    logic [XLEN-1:0]   reg_w_data;
    logic              jmp_do;
    logic [XLEN-1:0]   jmp_pc;

    logic              exp_stb;
    logic              exp_en;
    logic [REG_AW-1:0] exp_rd;
    logic [XLEN-1:0]   exp_data;
    logic              exp_jmp;
    logic [XLEN-1:0]   exp_jpc;
    int                n_tests;
    int                n_failed;
    int                n_other;

    exec_stage exec_stage_i (.*);

    exec_checker checker_i (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // flags: 0 back-to-back, 1 idle cycle after, 2 flush at next edge
    task automatic add_row(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                           input int rd_i, input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] imm_i, input int flags, input int e_en_i,
                           input logic [31:0] e_data_i, input int e_jmp_i,
                           input logic [31:0] e_jpc_i);
        row_t r;
        r.pc          = 32'h1000 + 32'(rows.size() * 4);
        r.opcode      = opc;
        r.funct3      = f3;
        r.funct7      = f7;
        r.rd          = 5'(rd_i);
        r.rs1_data    = rs1;
        r.rs2_data    = rs2;
        r.imm         = imm_i;
        r.gap         = (flags == 1);
        r.flush_after = (flags == 2);
        r.e_en        = (e_en_i != 0);
        r.e_rd        = (e_en_i != 0) ? 5'(rd_i) : 5'd0;  // rd only with a write
        r.e_data      = e_data_i;
        r.e_jmp       = (e_jmp_i != 0);
        r.e_jpc       = e_jpc_i;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // opc, f3, f7, rd, rs1, rs2, imm, flags, exp en, exp data, exp jmp, exp jmp_pc
        add_row(OPC_OP, F3_ADD, F7_BASE, 1, 'h7fffffff, 'h1, 'h0, 0, 1, 'h80000000, 0, 0);
        add_row(OPC_OP, F3_ADD, F7_ALT, 2, 'h5, 'h7, 'h0, 0, 1, 'hfffffffe, 0, 0);
        add_row(OPC_OP, F3_AND, F7_BASE, 3, 'hf0f0f0f0, 'hff00ff00, 'h0, 0, 1, 'hf000f000, 0, 0);
        add_row(OPC_OP, F3_OR, F7_BASE, 4, 'hf0f0f0f0, 'hff00ff00, 'h0, 0, 1, 'hfff0fff0, 0, 0);
        add_row(OPC_OP, F3_XOR, F7_BASE, 5, 'hf0f0f0f0, 'hff00ff00, 'h0, 0, 1, 'h0ff00ff0, 0, 0);
        add_row(OPC_OP, F3_SLL, F7_BASE, 6, 'h80000001, 'h24, 'h0, 0, 1, 'h10, 0, 0);
        add_row(OPC_OP, F3_SR, F7_BASE, 7, 'h80000000, 'h4, 'h0, 0, 1, 'h08000000, 0, 0);
        add_row(OPC_OP, F3_SR, F7_ALT, 8, 'h80000000, 'h4, 'h0, 0, 1, 'hf8000000, 0, 0);
        add_row(OPC_OP, F3_SLT, F7_BASE, 9, 'hffffffff, 'h1, 'h0, 0, 1, 'h1, 0, 0);
        add_row(OPC_OP, F3_SLTU, F7_BASE, 10, 'hffffffff, 'h1, 'h0, 1, 1, 'h0, 0, 0);
        add_row(OPC_OP_IMM, F3_ADD, F7_BASE, 11, 'ha, 'h0, 'hfff, 0, 1, 'h9, 0, 0);
        add_row(OPC_OP_IMM, F3_AND, F7_BASE, 12, 'h12345678, 'h0, 'h80f, 0, 1, 'h12345008, 0, 0);
        add_row(OPC_OP_IMM, F3_OR, F7_BASE, 13, 'hf0, 'h0, 'hf, 0, 1, 'hff, 0, 0);
        add_row(OPC_OP_IMM, F3_XOR, F7_BASE, 14, 'hff, 'h0, 'hfff, 0, 1, 'hffffff00, 0, 0);
        add_row(OPC_OP_IMM, F3_SLT, F7_BASE, 15, 'hfffffff0, 'h0, 'hff8, 0, 1, 'h1, 0, 0);
        add_row(OPC_OP_IMM, F3_SLTU, F7_BASE, 16, 'h5, 'h0, 'hfff, 0, 1, 'h1, 0, 0);
        add_row(OPC_OP_IMM, F3_SLL, F7_BASE, 17, 'h3, 'h0, 'h1f, 0, 1, 'h80000000, 0, 0);
        add_row(OPC_OP_IMM, F3_SR, F7_BASE, 18, 'hf0000000, 'h0, 'h1c, 0, 1, 'hf, 0, 0);
        add_row(OPC_OP_IMM, F3_SR, F7_ALT, 19, 'hf0000000, 'h0, 'h41c, 0, 1, 'hffffffff, 0, 0);
        add_row(OPC_LUI, F3_ADD, F7_BASE, 20, 'h0, 'h0, 'h87654000, 0, 1, 'h87654000, 0, 0);
        add_row(OPC_AUIPC, F3_ADD, F7_BASE, 21, 'h0, 'h0, 'hfffff000, 1, 1, 'h50, 0, 0);
        add_row(OPC_BRANCH, F3_BEQ, F7_BASE, 0, 'h5, 'h5, 'h11, 0, 0, 'h0, 1, 'h1064);
        add_row(OPC_BRANCH, F3_BEQ, F7_BASE, 0, 'h5, 'h6, 'h10, 0, 0, 'h0, 0, 0);
        add_row(OPC_BRANCH, F3_BNE, F7_BASE, 0, 'h1, 'h2, 'h1ff0, 0, 0, 'h0, 1, 'h104c);
        add_row(OPC_BRANCH, F3_BNE, F7_BASE, 0, 'h3, 'h3, 'h10, 0, 0, 'h0, 0, 0);
        add_row(OPC_BRANCH, F3_BLT, F7_BASE, 0, 'hfffffffe, 'h1, 'h100, 0, 0, 'h0, 1, 'h1164);
        add_row(OPC_BRANCH, F3_BLT, F7_BASE, 0, 'h1, 'hfffffffe, 'h10, 0, 0, 'h0, 0, 0);
        add_row(OPC_BRANCH, F3_BGE, F7_BASE, 0, 'h1, 'hfffffffe, 'h8, 0, 0, 'h0, 1, 'h1074);
        add_row(OPC_BRANCH, F3_BGE, F7_BASE, 0, 'hfffffffe, 'h1, 'h10, 0, 0, 'h0, 0, 0);
        add_row(OPC_BRANCH, F3_BLTU, F7_BASE, 0, 'h1, 'hfffffffe, 'h20, 0, 0, 'h0, 1, 'h1094);
        add_row(OPC_BRANCH, F3_BLTU, F7_BASE, 0, 'hfffffffe, 'h1, 'h10, 0, 0, 'h0, 0, 0);
        add_row(OPC_BRANCH, F3_BGEU, F7_BASE, 0, 'hfffffffe, 'h1, 'h1ffc, 0, 0, 'h0, 1, 'h1078);
        add_row(OPC_BRANCH, F3_BGEU, F7_BASE, 0, 'h1, 'hfffffffe, 'h10, 0, 0, 'h0, 0, 0);
        add_row(OPC_JAL, F3_ADD, F7_BASE, 1, 'h0, 'h0, 'h800, 0, 1, 'h1088, 1, 'h1884);
        add_row(OPC_JALR, F3_JALR, F7_BASE, 5, 'h2000, 'h0, 'h10, 0, 1, 'h108c, 1, 'h2010);
        add_row(OPC_JALR, F3_JALR, F7_BASE, 6, 'h3001, 'h0, 'hffe, 0, 1, 'h1090, 1, 'h2ffe);
        add_row(7'b0000011, 3'b010, F7_BASE, 7, 'h100, 'h0, 'h4, 1, 0, 'h0, 0, 0);  // lw
        add_row(OPC_OP, F3_ADD, F7_BASE, 9, 'h1, 'h1, 'h0, 2, 0, 'h0, 0, 0);  // dropped
        add_row(OPC_OP_IMM, F3_ADD, F7_BASE, 10, 'h20, 'h0, 'h5, 0, 1, 'h25, 0, 0);
        add_row(OPC_JAL, F3_ADD, F7_BASE, 2, 'h0, 'h0, 'h1ff8, 0, 1, 'h10a0, 1, 'h1094);
    endtask

    task automatic drive_row(input row_t r);
        in_valid = 1'b1;
        pc       = r.pc;
        opcode   = r.opcode;
        funct3   = r.funct3;
        funct7   = r.funct7;
        rd       = r.rd;
        rs1_data = r.rs1_data;
        rs2_data = r.rs2_data;
        imm      = r.imm;
        exp_stb  = 1'b1;
        exp_en   = r.e_en;
        exp_rd   = r.e_rd;
        exp_data = r.e_data;
        exp_jmp  = r.e_jmp;
        exp_jpc  = r.e_jpc;
    endtask

    task automatic go_idle();
        in_valid = 1'b0;
        exp_stb  = 1'b0;
    endtask

    initial begin
        wait (table_ready);
        #((rows.size() * 2 + 10) * 100);
        $display("timeout: the run did not finish within %0d ns",
                 (rows.size() * 2 + 10) * 100);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int total;
        rst_n    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        pc       = '0;
        opcode   = '0;
        funct3   = '0;
        funct7   = '0;
        rd       = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm      = '0;
        exp_stb  = 1'b0;
        exp_en   = 1'b0;
        exp_rd   = '0;
        exp_data = '0;
        exp_jmp  = 1'b0;
        exp_jpc  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            drive_row(rows[i]);
            @(negedge CLK);
            go_idle();
            if (rows[i].flush_after) begin
                flush = 1'b1;  // kills the row captured at the last edge
                @(negedge CLK);
                flush = 1'b0;
            end
            if (rows[i].gap)
                @(negedge CLK);
        end
        wait (n_tests == rows.size());
        repeat (2) @(negedge CLK);
        total = n_failed + n_other + exec_stage_i.sva_i.fail_count;
        $display("summary: %0d tests, %0d passed, %0d failed, %0d other errors, %0d assertion fails",
                 n_tests, n_tests - n_failed, n_failed, n_other, exec_stage_i.sva_i.fail_count);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_stage.f
design/exec_pkg.sv
design/exec_if.sv
design/stage_reg.sv
design/exec_decode.sv
design/exec_alu_branch.sv
design/exec_result.sv
design/exec_stage.sv
verif/exec_checker.sv
verif/exec_stage_sva.sv
verif/tb_exec_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || { echo "cannot enter project root"; exit 1; }

LOG=sim.log

verilator --binary --assert --top-module tb_exec_stage -f exec_stage.f \
    --Mdir obj_dir -o tb_exec_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_exec_stage +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
exit 1
